// File: source/board_pkg.sv
package board_pkg;

    // Push buttons on the board.
    localparam int w_key = 4;

    // Switch bits that set the gain shift.
    localparam int w_gain = 2;

    // Level bar LEDs.
    localparam int w_led = 4;

    // Binary display value.
    localparam int w_display = 16;

    // Clocks a key must hold a new level before it counts.
    localparam int debounce_cycles = 16;

endpackage

// File: source/audio_pkg.sv
package audio_pkg;

    localparam int w_sample = 24;
    localparam int w_mag    = w_sample - 1;  // Magnitude drops the sign bit.

    // Clocks per sck half period.
    localparam int sck_half_cycles = 4;

    // Sck periods per ws frame, left half then right half.
    localparam int frame_bits = 64;

    // LED bar steps, entry 0 is the lowest.
    localparam logic [board_pkg::w_led - 1:0][w_mag - 1:0] level_thresholds =
    {
        23'h400000,
        23'h200000,
        23'h100000,
        23'h080000
    };

    typedef struct packed
    {
        logic signed [w_sample - 1:0] data;
    } mic_sample_t;

    typedef struct packed
    {
        logic [board_pkg::w_key - 1:0] press;  // One clock per accepted press.
    } key_event_t;

    typedef enum logic [1:0]
    {
        idle,
        shift,
        offer
    } i2s_state_e;

    typedef enum logic
    {
        mode_instant,
        mode_peak
    } meter_mode_e;

endpackage

// File: source/mic_i2s_receiver.sv
`timescale 1ns/1ps

module mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sd,
    output logic                   sck,
    output logic                   ws,
    output audio_pkg::mic_sample_t sample,
    output logic                   sample_req,
    input  logic                   sample_ack
);

    import audio_pkg::*;

    logic [$clog2(sck_half_cycles) - 1:0] div_cnt;
    logic [$clog2(frame_bits) - 1:0]      bit_cnt;
    logic                                 div_end;
    logic                                 sck_rise;
    logic                                 sck_fall;
    logic                                 capture;
    logic                                 first_bit;
    logic                                 last_bit;
    logic                                 word_done;
    logic [w_sample - 1:0]                shift_reg;
    i2s_state_e                           state;

    assign div_end  = (div_cnt == sck_half_cycles - 1);
    assign sck_rise = div_end && !sck;  // Sck goes high on this edge.
    assign sck_fall = div_end && sck;
    assign ws       = bit_cnt[$clog2(frame_bits) - 1];  // High in the second half.

    // Data bits sit on sck periods 1 to 24 of the left half.
    assign capture   = sck_rise && !ws && (bit_cnt >= 1) && (bit_cnt <= w_sample);
    assign first_bit = capture && (bit_cnt == 1);
    assign last_bit  = capture && (bit_cnt == w_sample);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt    <= '0;
            sck        <= 1'b0;
            bit_cnt    <= '0;
            word_done  <= 1'b0;
            state      <= idle;
            sample_req <= 1'b0;
        end
        else
        begin
            if (div_end)
            begin
                div_cnt <= '0;
                sck     <= ~sck;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;

            word_done <= last_bit;

            case (state)
                idle:
                    if (first_bit)
                        state <= shift;  // A word started while free.
                shift:
                    if (word_done)
                    begin
                        state      <= offer;
                        sample_req <= 1'b1;
                    end
                offer:
                    // Words that finish here are lost.
                    if (sample_req && sample_ack)
                        sample_req <= 1'b0;
                    else if (!sample_req && !sample_ack)
                        state <= idle;
                default:
                    state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
            shift_reg <= {shift_reg[w_sample - 2:0], sd};  // MSB arrives first.

        if (state == shift && word_done)
            sample.data <= shift_reg;
    end

endmodule

// File: source/key_debouncer.sv
`timescale 1ns/1ps

module key_debouncer
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [board_pkg::w_key - 1:0] key,
    output audio_pkg::key_event_t         keys
);

    import board_pkg::*;
    import audio_pkg::*;

    logic [w_key - 1:0]                                sync_a;
    logic [w_key - 1:0]                                sync_b;
    logic [w_key - 1:0]                                accepted;
    logic [w_key - 1:0]                                settle;
    logic [w_key - 1:0][$clog2(debounce_cycles) - 1:0] stable_cnt;
    key_event_t                                        press_next;

    always_comb
    begin
        for (int i = 0; i < w_key; i++)
            settle[i] = (sync_b[i] != accepted[i]) && (stable_cnt[i] == debounce_cycles - 1);

        press_next.press = settle & sync_b & ~accepted;  // Only low to high.
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sync_a     <= '0;
            sync_b     <= '0;
            accepted   <= '0;
            stable_cnt <= '0;
            keys       <= '0;
        end
        else
        begin
            sync_a   <= key;
            sync_b   <= sync_a;
            keys     <= press_next;
            accepted <= accepted ^ settle;

            // Any return to the old level restarts the count.
            for (int i = 0; i < w_key; i++)
                if (sync_b[i] == accepted[i] || settle[i])
                    stable_cnt[i] <= '0;
                else
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
    end

endmodule

// File: source/level_meter.sv
`timescale 1ns/1ps

module level_meter
(
    input  logic                              clk,
    input  logic                              reset,
    input  audio_pkg::mic_sample_t            sample,
    input  logic                              sample_req,
    output logic                              sample_ack,
    input  audio_pkg::key_event_t             keys,
    input  logic [board_pkg::w_gain - 1:0]    gain,
    output logic [board_pkg::w_led - 1:0]     led,
    output logic [board_pkg::w_display - 1:0] display
);

    import board_pkg::*;
    import audio_pkg::*;

    logic [w_sample - 1:0]                abs_full;
    logic [w_mag - 1:0]                   magnitude;
    logic [w_mag + (1 << w_gain) - 2:0]   shifted;
    logic [w_mag - 1:0]                   gained;
    logic [w_mag - 1:0]                   latest;
    logic [w_mag - 1:0]                   latest_next;
    logic [w_mag - 1:0]                   peak;
    logic [w_mag - 1:0]                   peak_next;
    logic [w_mag - 1:0]                   shown_next;
    logic [w_led - 1:0]                   led_next;
    logic                                 take;
    meter_mode_e                          mode;
    meter_mode_e                          mode_next;

    always_comb
    begin
        abs_full  = sample.data[w_sample - 1] ? -sample.data : sample.data;
        magnitude = abs_full[w_sample - 1] ? '1 : abs_full[w_mag - 1:0];  // Most negative.

        shifted = {{((1 << w_gain) - 1){1'b0}}, magnitude} << gain;
        gained  = (|shifted[$left(shifted):w_mag]) ? '1 : shifted[w_mag - 1:0];

        take = sample_req && !sample_ack;  // Edge on which ack rises.

        latest_next = take ? gained : latest;

        peak_next = peak;
        if (take && gained > peak)
            peak_next = gained;
        if (keys.press[1])
            peak_next = '0;  // Clear wins over a new sample.

        mode_next = mode;
        if (keys.press[0])
            mode_next = (mode == mode_instant) ? mode_peak : mode_instant;

        shown_next = (mode_next == mode_peak) ? peak_next : latest_next;

        for (int i = 0; i < w_led; i++)
            led_next[i] = (shown_next >= level_thresholds[i]);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sample_ack <= 1'b0;
            latest     <= '0;
            peak       <= '0;
            mode       <= mode_instant;
            led        <= '0;
            display    <= '0;
        end
        else
        begin
            sample_ack <= sample_req;  // Follows req one clock later.
            latest     <= latest_next;
            peak       <= peak_next;
            mode       <= mode_next;
            led        <= led_next;
            display    <= shown_next[w_mag - 1 -: w_display];
        end
    end

endmodule

// File: source/board_top.sv
`timescale 1ns/1ps

module board_top
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic [board_pkg::w_key - 1:0]     key,
    input  logic [board_pkg::w_gain - 1:0]    sw,
    output logic                              sck,
    output logic                              ws,
    input  logic                              sd,
    output logic [board_pkg::w_led - 1:0]     led,
    output logic [board_pkg::w_display - 1:0] display
);

    import audio_pkg::*;

    mic_sample_t sample;
    logic        sample_req;
    logic        sample_ack;
    key_event_t  keys;

    mic_i2s_receiver i_mic
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sd         ( sd         ),
        .sck        ( sck        ),
        .ws         ( ws         ),
        .sample     ( sample     ),
        .sample_req ( sample_req ),
        .sample_ack ( sample_ack )
    );

    key_debouncer i_keys
    (
        .clk   ( clk   ),
        .reset ( reset ),
        .key   ( key   ),
        .keys  ( keys  )
    );

    level_meter i_meter
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sample     ( sample     ),
        .sample_req ( sample_req ),
        .sample_ack ( sample_ack ),
        .keys       ( keys       ),
        .gain       ( sw         ),  // Switches set the shift directly.
        .led        ( led        ),
        .display    ( display    )
    );

endmodule

// File: sim/board_top_assert.sv
`timescale 1ns/1ps

module board_top_assert
(
    input logic clk,
    input logic reset,
    input logic sck,
    input logic ws,
    input logic sample_req,
    input logic sample_ack
);

    int failures = 0;  // Failed assertions so far.

    // Ack only rises while the request is still up.
    ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        $rose(sample_ack) |-> sample_req)
        else
        begin
            $error("sample_ack rose while sample_req was low");
            failures++;
        end

    req_held: assert property (@(posedge clk) disable iff (reset)
        sample_req && !sample_ack |=> sample_req)
        else
        begin
            $error("sample_req dropped before sample_ack");
            failures++;
        end

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (reset)
        $changed(ws) |-> $fell(sck))
        else
        begin
            $error("ws changed away from a falling sck edge");
            failures++;
        end

    req_low_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !sample_req)
        else
        begin
            $error("sample_req not low after reset");
            failures++;
        end

endmodule

bind board_top board_top_assert board_assert
(
    .clk        ( clk        ),
    .reset      ( reset      ),
    .sck        ( sck        ),
    .ws         ( ws         ),
    .sample_req ( sample_req ),
    .sample_ack ( sample_ack )
);

// File: sim/board_top_tb.sv
`timescale 1ns/1ps

module board_top_tb;

    import board_pkg::*;
    import audio_pkg::*;

    localparam int     clk_period  = 8;
    localparam int     frames_used = 84;  // Up to two frames per sample, plus keys.
    localparam longint timeout_ns  =
        longint'(frames_used) * frame_bits * 2 * sck_half_cycles * clk_period * 3 / 2;
    localparam longint max_mag     = (longint'(1) << (w_sample - 1)) - 1;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [w_key - 1:0]     key;
    logic [w_gain - 1:0]    sw;
    logic                   sck;
    logic                   ws;
    logic                   sd;
    logic [w_led - 1:0]     led;
    logic [w_display - 1:0] display;

    logic [w_sample - 1:0]  mic_queue[$];
    int                     sent;
    int                     checks;
    int                     errors;
    logic [31:0]            rng_state;
    logic [31:0]            ref_latest;
    logic [31:0]            ref_peak;
    logic                   ref_peak_mode;

    board_top DUT
    (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .key     ( key     ),
        .sw      ( sw      ),
        .sck     ( sck     ),
        .ws      ( ws      ),
        .sd      ( sd      ),
        .led     ( led     ),
        .display ( display )
    );

    always #(clk_period / 2) clk = ~clk;

    // Microphone model that sends one queued word per left half and zeros when idle.
    initial
    begin : mic_model
        logic [w_sample - 1:0] word;
        logic                  last_ws;
        int                    bit_pos;
        sd      = 1'b0;
        word    = '0;
        last_ws = 1'b0;
        bit_pos = w_sample;
        forever
        begin
            @(negedge sck);
            @(negedge clk);
            if (!ws && last_ws)
            begin
                word = '0;
                if (mic_queue.size() > 0)
                begin
                    word = mic_queue.pop_front();
                    sent++;
                end
                bit_pos = 0;  // MSB goes out on the next fall.
                sd      = 1'b0;
            end
            else if (!ws && bit_pos < w_sample)
            begin
                sd = word[w_sample - 1 - bit_pos];
                bit_pos++;
            end
            else
                sd = 1'b0;
            last_ws = ws;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    function automatic logic [w_sample - 1:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:8];
    endfunction

    // Absolute value, gain shift and saturation to 23 bits.
    function automatic logic [31:0] gained_mag(input logic [w_sample - 1:0] s, input int g);
        longint v;
        v = longint'(signed'(s));
        if (v < 0)
            v = -v;
        if (v > max_mag)
            v = max_mag;
        v = v << g;
        if (v > max_mag)
            v = max_mag;
        return v[31:0];
    endfunction

    function automatic logic [w_led - 1:0] led_bar(input logic [31:0] v);
        logic [w_led - 1:0] bar;
        for (int i = 0; i < w_led; i++)
            bar[i] = (v >= (32'd1 << (19 + i)));  // Steps at 2^19 to 2^22.
        return bar;
    endfunction

    task automatic check_outputs(input string what);
        logic [31:0] shown;
        shown = ref_peak_mode ? ref_peak : ref_latest;
        check_value({what, " display"}, display, shown >> 7);
        check_value({what, " led"}, led, led_bar(shown));
    endtask

    // Queue a word, wait for its frame to end, then compare.
    task automatic send_sample(input logic [w_sample - 1:0] s, input string what);
        int          idx;
        logic [31:0] g;
        idx = sent;
        g   = gained_mag(s, sw);
        @(negedge clk);
        mic_queue.push_back(s);
        wait (sent > idx);
        @(posedge ws);
        repeat (4) @(negedge clk);
        ref_latest = g;
        if (g > ref_peak)
            ref_peak = g;
        check_outputs(what);
    endtask

    task automatic press_key(input int k, input int hold);
        @(negedge clk);
        key[k] = 1'b1;
        repeat (hold) @(negedge clk);
        key[k] = 1'b0;
        repeat (debounce_cycles + 8) @(negedge clk);  // Let the release settle.
    endtask

    task automatic reset_test();
        int   edges;
        int   clocks;
        int   falls;
        logic last_sck;
        logic last_ws;
        check_value("reset led", led, 0);
        check_value("reset display", display, 0);
        edges  = 0;
        clocks = 0;
        while (edges < 2)
        begin
            last_sck = sck;
            @(negedge clk);
            if (edges == 1)
                clocks++;
            if (sck && !last_sck)
                edges++;
        end
        check_value("sck period", clocks, 2 * sck_half_cycles);
        edges = 0;
        falls = 0;
        while (edges < 2)
        begin
            last_sck = sck;
            last_ws  = ws;
            @(negedge clk);
            if (edges == 1 && !sck && last_sck)
                falls++;
            if (ws && !last_ws)
                edges++;
        end
        check_value("ws frame", falls, frame_bits);
    endtask

    task automatic instant_test();
        logic [w_sample - 1:0] s;
        sw = '0;
        for (int i = 0; i < 10; i++)
        begin
            s               = next_random();
            s[w_sample - 1] = i[0];  // Alternate signs.
            if (i == 5)
                s = 24'h800000;
            send_sample(s, "instant");
        end
    endtask

    task automatic gain_test();
        int                    mag;
        logic [w_sample - 1:0] s;
        for (int g = 0; g < 4; g++)
        begin
            sw = g;
            for (int i = 0; i < w_led; i++)
            begin
                mag = (1 << (19 + i)) >> g;
                s   = i[0] ? -(mag - 1) : mag;  // Odd steps land just below.
                send_sample(s, "gain");
            end
            send_sample(24'h5A0000, "gain saturate");
        end
    endtask

    task automatic debounce_test();
        sw = '0;
        press_key(0, debounce_cycles / 2);
        send_sample(24'h123456, "after glitch");
        press_key(1, debounce_cycles + 8);
        ref_peak = '0;
        press_key(0, debounce_cycles + 8);
        ref_peak_mode = 1'b1;
        check_outputs("peak entry");
        send_sample(24'h654321, "peak large");
        send_sample(24'hF00000, "peak smaller");
        send_sample(24'h000321, "peak small");
    endtask

    task automatic peak_clear_test();
        press_key(1, debounce_cycles + 8);
        ref_peak = '0;
        check_outputs("peak clear");
        send_sample(24'h2ABCDE, "new peak");
        press_key(0, debounce_cycles + 8);
        ref_peak_mode = 1'b0;
        send_sample(24'hE00000, "instant again");  // Below the held peak.
    endtask

    initial
    begin
        reset         = 1'b1;
        key           = '0;
        sw            = '0;
        checks        = 0;
        errors        = 0;
        rng_state     = 32'd68;
        ref_latest    = '0;
        ref_peak      = '0;
        ref_peak_mode = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        reset_test();
        instant_test();
        gain_test();
        debounce_test();
        peak_clear_test();
        errors = errors + DUT.board_assert.failures;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(timeout_ns);
        $display("Timeout: the tests were still running after %0d ns", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: filelist.f
source/board_pkg.sv
source/audio_pkg.sv
source/mic_i2s_receiver.sv
source/key_debouncer.sv
source/level_meter.sv
source/board_top.sv
sim/board_top_assert.sv
sim/board_top_tb.sv
